//--- stream_buffer.f
common/fifo_cfg_pkg.sv
common/fifo_stat_pkg.sv
common/fifo_ctrl_if.sv
fifo/fifo_v3.sv
fifo/fifo_v2.sv
rtl/fifo_regs.sv
rtl/stream_buffer_top.sv
test/stream_buffer_checker.sv
test/tb_stream_buffer.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := tb_stream_buffer
FILELIST  := stream_buffer.f
RUN_FLAGS := +verilator+error+limit+100

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUN_FLAGS)

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_stream_buffer.sv
module tb_stream_buffer import fifo_cfg_pkg::*; ();

    localparam int DATA_WIDTH = 32;
    localparam int DEPTH      = 8;
    localparam int FULL_TH    = 6;    // thresholds out of reset
    localparam int EMPTY_TH   = 1;
    localparam int MAX_CYCLES = 2000; // about 1200 cycles of tests plus margin

    logic                  clk_i;
    logic                  reset_i;
    logic                  push_i;
    logic [DATA_WIDTH-1:0] data_i;
    logic                  pop_i;
    logic [DATA_WIDTH-1:0] data_o;
    logic                  full_o;
    logic                  empty_o;
    logic                  alm_full_o;
    logic                  alm_empty_o;
    logic                  cfg_we_i;
    logic [1:0]            cfg_addr_i;
    logic [15:0]           cfg_wdata_i;
    logic [15:0]           cfg_rdata_o;

    logic [DATA_WIDTH-1:0] model_q [$]; // reference queue, head at index 0
    int                    thr_full  = FULL_TH;
    int                    thr_empty = EMPTY_TH;
    bit                    flush_pulse = 1'b0; // model copy of the flush register
    logic [15:0]           lfsr_q = 16'd65;
    int                    cycle_cnt = 0;
    string                 test_name = "reset";

    stream_buffer_top #(
        .DATA_WIDTH   (DATA_WIDTH),
        .DEPTH        (DEPTH),
        .FALL_THROUGH (1'b0),
        .ALM_FULL_TH  (FULL_TH),
        .ALM_EMPTY_TH (EMPTY_TH)
    ) uut (
        .clk_i, .reset_i, .push_i, .data_i, .pop_i, .data_o,
        .full_o, .empty_o, .alm_full_o, .alm_empty_o,
        .cfg_we_i, .cfg_addr_i, .cfg_wdata_i, .cfg_rdata_o
    );

    bind fifo_v3 stream_buffer_checker #(.DEPTH(DEPTH)) i_checker (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .full_i  (full_o),
        .empty_i (empty_o),
        .usage_i (usage_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // hard stop, run must never hang
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run went past %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q); // one step per bit taken
            bits   = {bits[30:0], lfsr_q[0]};
        end
    endtask

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("ERROR %s: %s expected %0h actual %0h", test_name, what, exp, act);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // apply the inputs that were present before this edge
    task automatic update_model();
        bit pop_ok;
        bit push_ok;
        pop_ok  = pop_i && (model_q.size() != 0);
        push_ok = push_i && ((model_q.size() < DEPTH) || pop_i); // pop frees a slot
        if (flush_pulse) begin
            model_q.delete(); // traffic during the pulse is lost
        end else begin
            if (pop_ok) begin
                void'(model_q.pop_front());
            end
            if (push_ok) begin
                model_q.push_back(data_i);
            end
        end
        if (cfg_we_i && (cfg_addr_i == ADDR_CFG)) begin
            thr_full  = 32'(cfg_wdata_i[15:8]);
            thr_empty = 32'(cfg_wdata_i[7:0]);
        end
        flush_pulse = cfg_we_i && (cfg_addr_i == ADDR_CMD) && cfg_wdata_i[15];
    endtask

    task automatic check_outputs();
        int          cnt;
        logic [15:0] exp_rdata;
        cnt = model_q.size();
        check_eq("empty_o", 32'(cnt == 0), 32'(empty_o));
        check_eq("full_o", 32'(cnt == DEPTH), 32'(full_o));
        check_eq("alm_full_o", 32'(cnt >= thr_full), 32'(alm_full_o));
        check_eq("alm_empty_o", 32'(cnt <= thr_empty), 32'(alm_empty_o));
        if (cnt != 0) begin
            check_eq("data_o", model_q[0], data_o); // head in push order
        end
        if (cfg_addr_i == ADDR_STATUS) begin
            // count, full, empty, almost full, almost empty, zeros
            exp_rdata = {8'(cnt), cnt == DEPTH, cnt == 0, cnt >= thr_full,
                         cnt <= thr_empty, 4'b0000};
        end else if (cfg_addr_i == ADDR_CFG) begin
            exp_rdata = {8'(thr_full), 8'(thr_empty)};
        end else begin
            exp_rdata = '0;
        end
        check_eq("cfg_rdata_o", 32'(exp_rdata), 32'(cfg_rdata_o));
        assert (uut.i_fifo_v2.i_fifo_v3.i_checker.fail_cnt == 0) else begin
            $display("a core assertion fired during %s", test_name);
            $display("Some tests failed");
            $fatal(1, "core rule broken");
        end
    endtask

    task automatic drive_cycle(input logic push, input logic [31:0] data, input logic pop,
                               input logic we, input logic [1:0] addr, input logic [15:0] wdata);
        @(posedge clk_i);
        update_model();
        push_i      <= push;
        data_i      <= data;
        pop_i       <= pop;
        cfg_we_i    <= we;
        cfg_addr_i  <= addr;
        cfg_wdata_i <= wdata;
        @(negedge clk_i); // outputs settled mid-cycle
        check_outputs();
    endtask

    // weights out of 4, flush writes about one cycle in 16 when enabled
    task automatic random_traffic(input int cycles, input int push_w, input int pop_w,
                                  input bit with_flush);
        logic [31:0] b_push;
        logic [31:0] b_pop;
        logic [31:0] data;
        logic [31:0] b_addr;
        logic [31:0] b_cmd;
        logic        we;
        logic [1:0]  addr;
        logic [15:0] wdata;
        for (int i = 0; i < cycles; i++) begin
            draw_bits(2, b_push);
            draw_bits(2, b_pop);
            draw_bits(32, data);
            draw_bits(2, b_addr);
            we    = 1'b0;
            addr  = b_addr[1:0]; // reads sweep all four addresses
            wdata = '0;
            if (with_flush) begin
                draw_bits(4, b_cmd);
                if (b_cmd == 0) begin
                    we    = 1'b1;
                    addr  = ADDR_CMD;
                    wdata = 16'h8000;
                end
            end
            drive_cycle(b_push < push_w, data, b_pop < pop_w, we, addr, wdata);
        end
    endtask

    initial begin
        logic [31:0] data;
        reset_i     = 1'b1;
        push_i      = 1'b0;
        data_i      = '0;
        pop_i       = 1'b0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = ADDR_STATUS;
        cfg_wdata_i = '0;
        repeat (10) @(posedge clk_i);
        reset_i <= 1'b0;
        drive_cycle(0, 0, 0, 0, ADDR_STATUS, 0);
        drive_cycle(0, 0, 0, 0, ADDR_CFG, 0); // reset thresholds read back

        test_name = "fill_drain";
        for (int i = 0; i < DEPTH + 2; i++) begin
            draw_bits(32, data);
            drive_cycle(1, data, 0, 0, ADDR_STATUS, 0); // last two pushes get dropped
        end
        drive_cycle(1, 32'hcafe_0001, 1, 0, ADDR_STATUS, 0); // push and pop while full
        drive_cycle(0, 0, 0, 0, ADDR_STATUS, 0);
        check_eq("full_after_fill", 1, 32'(full_o));
        for (int i = 0; i < DEPTH + 1; i++) begin
            drive_cycle(0, 0, 1, 0, ADDR_STATUS, 0);
        end
        drive_cycle(0, 0, 0, 0, ADDR_STATUS, 0);
        check_eq("empty_after_drain", 1, 32'(empty_o));

        test_name = "random_reset_thresholds";
        random_traffic(300, 3, 2, 0); // leans toward full
        random_traffic(300, 2, 3, 0); // leans toward empty

        test_name = "thresholds";
        drive_cycle(0, 0, 0, 1, ADDR_CFG, {8'd4, 8'd2});
        drive_cycle(0, 0, 0, 0, ADDR_CFG, 0); // written word reads back
        random_traffic(150, 3, 3, 0);
        drive_cycle(0, 0, 0, 1, ADDR_CFG, {8'd7, 8'd3});
        drive_cycle(0, 0, 0, 0, ADDR_CFG, 0);
        random_traffic(150, 3, 2, 0);

        test_name = "flush";
        for (int i = 0; i < 5; i++) begin
            draw_bits(32, data);
            drive_cycle(1, data, 0, 0, ADDR_STATUS, 0);
        end
        drive_cycle(0, 0, 0, 1, ADDR_CMD, 16'h8000);
        drive_cycle(1, 32'hdead_0002, 1, 0, ADDR_STATUS, 0); // lands in the pulse cycle
        drive_cycle(0, 0, 0, 0, ADDR_STATUS, 0);
        check_eq("empty_after_flush", 1, 32'(empty_o));
        random_traffic(200, 3, 2, 1);

        test_name = "final";
        drive_cycle(0, 0, 0, 0, ADDR_STATUS, 0);
        drive_cycle(0, 0, 0, 0, ADDR_STATUS, 0);
        if (uut.i_fifo_v2.i_fifo_v3.i_checker.fail_cnt == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "core rule broken");
        end
    end

endmodule

//--- test/stream_buffer_checker.sv
module stream_buffer_checker import fifo_stat_pkg::*; #(
    parameter int unsigned DEPTH = 8
) (
    input logic                 clk_i,
    input logic                 reset_i,
    input logic                 flush_i,   // flush pulse seen by the core
    input logic                 full_i,
    input logic                 empty_i,
    input logic [CNT_WIDTH-1:0] usage_i    // fill count of the core
);

    // rules on the storage core, bound onto every fifo_v3

    localparam logic [CNT_WIDTH-1:0] MAX_CNT = CNT_WIDTH'(DEPTH);

    int unsigned fail_cnt = 0; // fired assertions, polled by the testbench

    // count can never pass the number of slots
    usage_bound_a : assert property (
        @(posedge clk_i) disable iff (reset_i)
        usage_i <= MAX_CNT
    ) else begin
        $error("fill count %0d above depth %0d", usage_i, DEPTH);
        fail_cnt++;
    end

    // a queue cannot be full and empty at once
    flags_exclusive_a : assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(full_i && empty_i)
    ) else begin
        $error("full and empty high together");
        fail_cnt++;
    end

    // one edge after the pulse nothing is left
    flush_clears_a : assert property (
        @(posedge clk_i) disable iff (reset_i)
        flush_i |=> (usage_i == '0)
    ) else begin
        $error("queue not empty one cycle after flush");
        fail_cnt++;
    end

endmodule

//--- rtl/stream_buffer_top.sv
module stream_buffer_top import fifo_cfg_pkg::*; #(
    parameter int unsigned DATA_WIDTH   = 32,
    parameter int unsigned DEPTH        = 8,    // 2 to 255
    parameter bit          FALL_THROUGH = 1'b0,
    parameter int unsigned ALM_FULL_TH  = 6,    // reset value, reprogrammable
    parameter int unsigned ALM_EMPTY_TH = 1     // reset value, reprogrammable
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    // data path
    input  logic                      push_i,
    input  logic [DATA_WIDTH-1:0]     data_i,
    input  logic                      pop_i,
    output logic [DATA_WIDTH-1:0]     data_o,
    // fill flags
    output logic                      full_o,
    output logic                      empty_o,
    output logic                      alm_full_o,
    output logic                      alm_empty_o,
    // register port
    input  logic                      cfg_we_i,
    input  logic [CFG_ADDR_WIDTH-1:0] cfg_addr_i,
    input  logic [CFG_WIDTH-1:0]      cfg_wdata_i,
    output logic [CFG_WIDTH-1:0]      cfg_rdata_o
);

    fifo_ctrl_if ctrl ();

    fifo_regs #(
        .ALM_FULL_TH  (ALM_FULL_TH),
        .ALM_EMPTY_TH (ALM_EMPTY_TH)
    ) i_fifo_regs (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .ctrl        (ctrl.regs_mp)
    );

    fifo_v2 #(
        .DATA_WIDTH   (DATA_WIDTH),
        .DEPTH        (DEPTH),
        .FALL_THROUGH (FALL_THROUGH)
    ) i_fifo_v2 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .push_i  (push_i),
        .data_i  (data_i),
        .pop_i   (pop_i),
        .data_o  (data_o),
        .ctrl    (ctrl.fifo_mp)
    );

    // flags straight off the link, no extra stage
    assign full_o      = ctrl.full;
    assign empty_o     = ctrl.empty;
    assign alm_full_o  = ctrl.alm_full;
    assign alm_empty_o = ctrl.alm_empty;

endmodule

//--- rtl/fifo_regs.sv
module fifo_regs
    import fifo_cfg_pkg::*;
    import fifo_stat_pkg::*;
#(
    parameter int unsigned ALM_FULL_TH  = 6, // almost-full threshold after reset
    parameter int unsigned ALM_EMPTY_TH = 1  // almost-empty threshold after reset
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      cfg_we_i,    // write strobe
    input  logic [CFG_ADDR_WIDTH-1:0] cfg_addr_i,
    input  logic [CFG_WIDTH-1:0]      cfg_wdata_i,
    output logic [CFG_WIDTH-1:0]      cfg_rdata_o, // combinational readback
    fifo_ctrl_if.regs_mp              ctrl
);

    fifo_cfg_word_u wr_word; // incoming word, decoded per address
    fifo_cfg_word_u cfg_word; // threshold readback
    fifo_status_t   status;

    logic                 thr_wr;  // write hits ADDR_CFG
    logic                 cmd_wr;  // write hits ADDR_CMD
    logic [CNT_WIDTH-1:0] alm_full_th_q;
    logic [CNT_WIDTH-1:0] alm_empty_th_q;
    logic                 flush_q; // single-cycle pulse

    assign wr_word = cfg_wdata_i;
    assign thr_wr  = cfg_we_i && (cfg_addr_i == ADDR_CFG);
    assign cmd_wr  = cfg_we_i && (cfg_addr_i == ADDR_CMD);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            alm_full_th_q  <= CNT_WIDTH'(ALM_FULL_TH);
            alm_empty_th_q <= CNT_WIDTH'(ALM_EMPTY_TH);
            flush_q        <= 1'b0;
        end else begin
            if (thr_wr) begin
                alm_full_th_q  <= wr_word.thr.alm_full_th;
                alm_empty_th_q <= wr_word.thr.alm_empty_th;
            end
            // high only in the cycle after a command write with the flush bit
            flush_q <= cmd_wr && wr_word.cmd.flush;
        end
    end

    assign ctrl.flush        = flush_q;
    assign ctrl.alm_full_th  = alm_full_th_q;
    assign ctrl.alm_empty_th = alm_empty_th_q;

    // live status assembled from the queue side of the link
    always_comb begin
        status.usage     = ctrl.usage;
        status.full      = ctrl.full;
        status.empty     = ctrl.empty;
        status.alm_full  = ctrl.alm_full;
        status.alm_empty = ctrl.alm_empty;
        status.rsvd      = '0;
    end

    always_comb begin
        cfg_word.thr.alm_full_th  = alm_full_th_q;
        cfg_word.thr.alm_empty_th = alm_empty_th_q;
    end

    always_comb begin
        case (cfg_addr_i)
            ADDR_STATUS: cfg_rdata_o = status;
            ADDR_CFG:    cfg_rdata_o = cfg_word;
            default:     cfg_rdata_o = '0; // command address and unused slot read zero
        endcase
    end

endmodule

//--- fifo/fifo_v2.sv
module fifo_v2 import fifo_stat_pkg::*; #(
    parameter int unsigned DATA_WIDTH   = 32,
    parameter int unsigned DEPTH        = 8,
    parameter bit          FALL_THROUGH = 1'b0
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  push_i,   // write strobe, dropped when full
    input  logic [DATA_WIDTH-1:0] data_i,
    input  logic                  pop_i,    // read strobe, ignored when empty
    output logic [DATA_WIDTH-1:0] data_o,
    fifo_ctrl_if.fifo_mp          ctrl      // thresholds and flush in, status out
);

    logic [CNT_WIDTH-1:0] usage; // fill count from the core
    logic                 full;
    logic                 empty;

    // almost flags compare against the live thresholds
    assign ctrl.alm_full  = (usage >= ctrl.alm_full_th);
    assign ctrl.alm_empty = (usage <= ctrl.alm_empty_th);

    // status back to the register block
    assign ctrl.usage = usage;
    assign ctrl.full  = full;
    assign ctrl.empty = empty;

    fifo_v3 #(
        .DATA_WIDTH   (DATA_WIDTH),
        .DEPTH        (DEPTH),
        .FALL_THROUGH (FALL_THROUGH)
    ) i_fifo_v3 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .flush_i (ctrl.flush), // pulse from the command register
        .push_i  (push_i),
        .data_i  (data_i),
        .pop_i   (pop_i),
        .full_o  (full),
        .empty_o (empty),
        .usage_o (usage),
        .data_o  (data_o)
    );

endmodule

//--- fifo/fifo_v3.sv
module fifo_v3 import fifo_stat_pkg::*; #(
    parameter int unsigned DATA_WIDTH   = 32,   // payload width
    parameter int unsigned DEPTH        = 8,    // entries, 2 to 255
    parameter bit          FALL_THROUGH = 1'b0  // pass data_i through when empty
) (
    input  logic                  clk_i,
    input  logic                  reset_i,   // sync, active high
    input  logic                  flush_i,   // drop all entries at the next edge
    input  logic                  push_i,    // write strobe
    input  logic [DATA_WIDTH-1:0] data_i,
    input  logic                  pop_i,     // read strobe
    output logic                  full_o,
    output logic                  empty_o,
    output logic [CNT_WIDTH-1:0]  usage_o,   // fill count
    output logic [DATA_WIDTH-1:0] data_o     // head of queue
);

    localparam int unsigned ADDR_DEPTH = $clog2(DEPTH);
    localparam logic [ADDR_DEPTH-1:0] LAST_ADDR = ADDR_DEPTH'(DEPTH - 1);
    localparam logic [CNT_WIDTH-1:0]  FULL_CNT  = CNT_WIDTH'(DEPTH);

    logic [DATA_WIDTH-1:0] mem_q [DEPTH]; // storage, no reset needed
    logic [ADDR_DEPTH-1:0] rd_ptr_q, rd_ptr_d;
    logic [ADDR_DEPTH-1:0] wr_ptr_q, wr_ptr_d;
    logic [CNT_WIDTH-1:0]  cnt_q, cnt_d;

    logic bypass;  // empty and fall-through, data_i shows on data_o
    logic push_ok; // push accepted this cycle
    logic pop_ok;  // pop accepted this cycle
    logic wr_en;   // entry actually written to storage
    logic rd_en;   // entry actually removed from storage

    assign bypass  = FALL_THROUGH && (cnt_q == '0) && push_i;
    assign full_o  = (cnt_q == FULL_CNT);
    assign empty_o = (cnt_q == '0) && !bypass;
    assign usage_o = cnt_q;

    // a pop while full frees the slot the push needs
    assign push_ok = push_i && (!full_o || pop_i) && !flush_i;
    assign pop_ok  = pop_i && !empty_o && !flush_i;

    // bypassed word popped in the same cycle never touches storage
    assign wr_en = push_ok && !(bypass && pop_i);
    assign rd_en = pop_ok && !bypass;

    assign data_o = bypass ? data_i : mem_q[rd_ptr_q];

    always_comb begin
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        cnt_d    = cnt_q;

        if (wr_en) begin
            wr_ptr_d = (wr_ptr_q == LAST_ADDR) ? '0 : wr_ptr_q + 1'b1; // wrap at depth
        end
        if (rd_en) begin
            rd_ptr_d = (rd_ptr_q == LAST_ADDR) ? '0 : rd_ptr_q + 1'b1;
        end

        case ({wr_en, rd_en})
            2'b10:   cnt_d = cnt_q + 1'b1;
            2'b01:   cnt_d = cnt_q - 1'b1;
            default: cnt_d = cnt_q; // idle, or push and pop cancel out
        endcase

        // flush wins over any traffic in the same cycle
        if (flush_i) begin
            rd_ptr_d = '0;
            wr_ptr_d = '0;
            cnt_d    = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

    // payload write port
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

//--- common/fifo_ctrl_if.sv
interface fifo_ctrl_if import fifo_stat_pkg::*; ();

    // control and status link between register block and queue

    // driven by the register block
    logic                 flush;        // one-cycle flush pulse
    logic [CNT_WIDTH-1:0] alm_full_th;  // run-time almost-full threshold
    logic [CNT_WIDTH-1:0] alm_empty_th; // run-time almost-empty threshold

    // driven by the queue
    logic [CNT_WIDTH-1:0] usage;        // current fill count
    logic                 full;
    logic                 empty;
    logic                 alm_full;
    logic                 alm_empty;

    // register side
    modport regs_mp (
        output flush,
        output alm_full_th,
        output alm_empty_th,
        input  usage,
        input  full,
        input  empty,
        input  alm_full,
        input  alm_empty
    );

    // queue side, directions mirrored
    modport fifo_mp (
        input  flush,
        input  alm_full_th,
        input  alm_empty_th,
        output usage,
        output full,
        output empty,
        output alm_full,
        output alm_empty
    );

endinterface

//--- common/fifo_stat_pkg.sv
package fifo_stat_pkg;

    // fill count width, sets the upper bound on the queue depth
    localparam int unsigned CNT_WIDTH = 8;

    // status word as seen at ADDR_STATUS
    // msb first: count in [15:8], flags in [7:4], zeros in [3:0]
    typedef struct packed {
        logic [CNT_WIDTH-1:0] usage;     // entries currently held
        logic                 full;      // no free slot left
        logic                 empty;     // nothing to pop
        logic                 alm_full;  // usage >= almost-full threshold
        logic                 alm_empty; // usage <= almost-empty threshold
        logic [3:0]           rsvd;      // reads as zero
    } fifo_status_t;

endpackage

//--- common/fifo_cfg_pkg.sv
package fifo_cfg_pkg;

    // register port geometry
    localparam int unsigned CFG_WIDTH      = 16;
    localparam int unsigned CFG_ADDR_WIDTH = 2;

    // register map
    localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_CFG    = 2'd0; // thresholds, read and write
    localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_STATUS = 2'd1; // live status, read only
    localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_CMD    = 2'd2; // commands, write only

    // one write word, two meanings depending on the address
    typedef union packed {
        // view at ADDR_CFG
        struct packed {
            logic [CFG_WIDTH/2-1:0] alm_full_th;  // upper byte
            logic [CFG_WIDTH/2-1:0] alm_empty_th; // lower byte
        } thr;
        // view at ADDR_CMD
        struct packed {
            logic                   flush;        // bit 15, request a queue flush
            logic [CFG_WIDTH-2:0]   rsvd;         // ignored on write
        } cmd;
    } fifo_cfg_word_u;

endpackage
